//--- src/cpuCtrlPkg.sv
package cpuCtrlPkg;

	typedef logic [31:0] instrT;  // Full instruction word
	typedef logic [4:0] opcodeT;
	typedef logic [2:0] stepT;    // Execute step counter

	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 27;

	// Opcode field encodings
	localparam opcodeT OPC_LD      = 5'b00000;
	localparam opcodeT OPC_LDI     = 5'b00001;
	localparam opcodeT OPC_ST      = 5'b00010;
	localparam opcodeT OPC_ADD     = 5'b00011;
	localparam opcodeT OPC_SUB     = 5'b00100;
	localparam opcodeT OPC_AND     = 5'b00101;
	localparam opcodeT OPC_OR      = 5'b00110;
	localparam opcodeT OPC_SHR     = 5'b00111;
	localparam opcodeT OPC_SHRA    = 5'b01000;
	localparam opcodeT OPC_SHL     = 5'b01001;
	localparam opcodeT OPC_ROR     = 5'b01010;
	localparam opcodeT OPC_ROL     = 5'b01011;
	localparam opcodeT OPC_ADDI    = 5'b01100;
	localparam opcodeT OPC_ANDI    = 5'b01101;
	localparam opcodeT OPC_ORI     = 5'b01110;
	localparam opcodeT OPC_MUL     = 5'b01111;
	localparam opcodeT OPC_DIV     = 5'b10000;
	localparam opcodeT OPC_NEG     = 5'b10001;
	localparam opcodeT OPC_NOT     = 5'b10010;
	localparam opcodeT OPC_BR      = 5'b10011;
	localparam opcodeT OPC_JR      = 5'b10100;
	localparam opcodeT OPC_JAL     = 5'b10101;
	localparam opcodeT OPC_RESTART = 5'b11010;
	localparam opcodeT OPC_HALT    = 5'b11011;

	typedef enum logic [2:0] {
		phIdle, phFetch0, phFetch1, phFetch2, phExecute, phHalted
	} phaseE;

	typedef enum logic [3:0] {
		clsAluReg, clsAluImm, clsLoadImm, clsMul, clsDiv, clsUnary, clsBranch,
		clsLoad, clsStore, clsJumpReg, clsJumpLink, clsRestart, clsHalt, clsIllegal
	} instrClassE;

	typedef enum logic [3:0] {
		aluNone, aluAdd, aluSub, aluAnd, aluOr, aluShr, aluShra, aluShl,
		aluRor, aluRol, aluMul, aluDiv, aluNeg, aluNot, aluBranch
	} aluOpE;

	// Final execute step of each class
	localparam stepT LAST_STEP_ALU_REG   = 3'd2;
	localparam stepT LAST_STEP_ALU_IMM   = 3'd2;
	localparam stepT LAST_STEP_LOAD_IMM  = 3'd2;
	localparam stepT LAST_STEP_JUMP_LINK = 3'd2;
	localparam stepT LAST_STEP_MUL       = 3'd3;
	localparam stepT LAST_STEP_DIV       = 3'd4;
	localparam stepT LAST_STEP_UNARY     = 3'd1;
	localparam stepT LAST_STEP_BRANCH    = 3'd3;
	localparam stepT LAST_STEP_LOAD      = 3'd4;
	localparam stepT LAST_STEP_STORE     = 3'd4;
	localparam stepT LAST_STEP_JUMP_REG  = 3'd0;

	localparam stepT DIV_WAIT_STEP = 3'd1;  // Divide holds here for divDone

endpackage

//--- src/ctrlStepIf.sv
interface ctrlStepIf;

	cpuCtrlPkg::instrClassE iClass;  // Decoded instruction class
	cpuCtrlPkg::aluOpE aluOp;        // Operation fixed by opcode
	cpuCtrlPkg::phaseE phase;
	cpuCtrlPkg::stepT step;          // Valid in execute only

	modport decoder (
		output iClass,
		output aluOp
	);

	modport sequencer (
		input iClass,
		output phase,
		output step
	);

	modport generator (
		input iClass,
		input aluOp,
		input phase,
		input step
	);

endinterface

//--- src/opcodeDecoder.sv
module opcodeDecoder (
	input cpuCtrlPkg::instrT ir,
	ctrlStepIf.decoder stepIf
);

	cpuCtrlPkg::opcodeT opcode;

	assign opcode = ir[cpuCtrlPkg::OPC_MSB:cpuCtrlPkg::OPC_LSB];

	always_comb begin
		case (opcode)
			cpuCtrlPkg::OPC_ADD, cpuCtrlPkg::OPC_SUB, cpuCtrlPkg::OPC_AND,
			cpuCtrlPkg::OPC_OR, cpuCtrlPkg::OPC_SHR, cpuCtrlPkg::OPC_SHRA,
			cpuCtrlPkg::OPC_SHL, cpuCtrlPkg::OPC_ROR,
			cpuCtrlPkg::OPC_ROL: stepIf.iClass = cpuCtrlPkg::clsAluReg;
			cpuCtrlPkg::OPC_ADDI, cpuCtrlPkg::OPC_ANDI,
			cpuCtrlPkg::OPC_ORI: stepIf.iClass = cpuCtrlPkg::clsAluImm;
			cpuCtrlPkg::OPC_LDI: stepIf.iClass = cpuCtrlPkg::clsLoadImm;
			cpuCtrlPkg::OPC_MUL: stepIf.iClass = cpuCtrlPkg::clsMul;
			cpuCtrlPkg::OPC_DIV: stepIf.iClass = cpuCtrlPkg::clsDiv;
			cpuCtrlPkg::OPC_NEG, cpuCtrlPkg::OPC_NOT: stepIf.iClass = cpuCtrlPkg::clsUnary;
			cpuCtrlPkg::OPC_BR: stepIf.iClass = cpuCtrlPkg::clsBranch;
			cpuCtrlPkg::OPC_LD: stepIf.iClass = cpuCtrlPkg::clsLoad;
			cpuCtrlPkg::OPC_ST: stepIf.iClass = cpuCtrlPkg::clsStore;
			cpuCtrlPkg::OPC_JR: stepIf.iClass = cpuCtrlPkg::clsJumpReg;
			cpuCtrlPkg::OPC_JAL: stepIf.iClass = cpuCtrlPkg::clsJumpLink;
			cpuCtrlPkg::OPC_RESTART: stepIf.iClass = cpuCtrlPkg::clsRestart;
			cpuCtrlPkg::OPC_HALT: stepIf.iClass = cpuCtrlPkg::clsHalt;
			default: stepIf.iClass = cpuCtrlPkg::clsIllegal;  // Unused codes stop the CPU
		endcase
	end

	// Address arithmetic of ld, st and ldi goes through the adder too
	always_comb begin
		case (opcode)
			cpuCtrlPkg::OPC_ADD, cpuCtrlPkg::OPC_ADDI, cpuCtrlPkg::OPC_LD,
			cpuCtrlPkg::OPC_LDI, cpuCtrlPkg::OPC_ST: stepIf.aluOp = cpuCtrlPkg::aluAdd;
			cpuCtrlPkg::OPC_SUB: stepIf.aluOp = cpuCtrlPkg::aluSub;
			cpuCtrlPkg::OPC_AND, cpuCtrlPkg::OPC_ANDI: stepIf.aluOp = cpuCtrlPkg::aluAnd;
			cpuCtrlPkg::OPC_OR, cpuCtrlPkg::OPC_ORI: stepIf.aluOp = cpuCtrlPkg::aluOr;
			cpuCtrlPkg::OPC_SHR: stepIf.aluOp = cpuCtrlPkg::aluShr;
			cpuCtrlPkg::OPC_SHRA: stepIf.aluOp = cpuCtrlPkg::aluShra;
			cpuCtrlPkg::OPC_SHL: stepIf.aluOp = cpuCtrlPkg::aluShl;
			cpuCtrlPkg::OPC_ROR: stepIf.aluOp = cpuCtrlPkg::aluRor;
			cpuCtrlPkg::OPC_ROL: stepIf.aluOp = cpuCtrlPkg::aluRol;
			cpuCtrlPkg::OPC_MUL: stepIf.aluOp = cpuCtrlPkg::aluMul;
			cpuCtrlPkg::OPC_DIV: stepIf.aluOp = cpuCtrlPkg::aluDiv;
			cpuCtrlPkg::OPC_NEG: stepIf.aluOp = cpuCtrlPkg::aluNeg;
			cpuCtrlPkg::OPC_NOT: stepIf.aluOp = cpuCtrlPkg::aluNot;
			cpuCtrlPkg::OPC_BR: stepIf.aluOp = cpuCtrlPkg::aluBranch;
			default: stepIf.aluOp = cpuCtrlPkg::aluNone;  // No ALU use
		endcase
	end

endmodule

//--- src/stepSequencer.sv
module stepSequencer (
	input logic clk,
	input logic rstN,
	input logic stop,
	input logic divDone,
	ctrlStepIf.sequencer stepIf
);

	cpuCtrlPkg::phaseE phaseQ;
	cpuCtrlPkg::phaseE phaseD;
	cpuCtrlPkg::stepT stepQ;
	cpuCtrlPkg::stepT stepD;
	cpuCtrlPkg::stepT lastStep;
	logic divWait;
	logic stopClass;

	always_comb begin
		case (stepIf.iClass)
			cpuCtrlPkg::clsAluReg: lastStep = cpuCtrlPkg::LAST_STEP_ALU_REG;
			cpuCtrlPkg::clsAluImm: lastStep = cpuCtrlPkg::LAST_STEP_ALU_IMM;
			cpuCtrlPkg::clsLoadImm: lastStep = cpuCtrlPkg::LAST_STEP_LOAD_IMM;
			cpuCtrlPkg::clsMul: lastStep = cpuCtrlPkg::LAST_STEP_MUL;
			cpuCtrlPkg::clsDiv: lastStep = cpuCtrlPkg::LAST_STEP_DIV;
			cpuCtrlPkg::clsUnary: lastStep = cpuCtrlPkg::LAST_STEP_UNARY;
			cpuCtrlPkg::clsBranch: lastStep = cpuCtrlPkg::LAST_STEP_BRANCH;
			cpuCtrlPkg::clsLoad: lastStep = cpuCtrlPkg::LAST_STEP_LOAD;
			cpuCtrlPkg::clsStore: lastStep = cpuCtrlPkg::LAST_STEP_STORE;
			cpuCtrlPkg::clsJumpReg: lastStep = cpuCtrlPkg::LAST_STEP_JUMP_REG;
			cpuCtrlPkg::clsJumpLink: lastStep = cpuCtrlPkg::LAST_STEP_JUMP_LINK;
			default: lastStep = 3'd0;  // Restart, halt and illegal leave in step 0
		endcase
	end

	assign divWait = (stepIf.iClass == cpuCtrlPkg::clsDiv) &&
		(stepQ == cpuCtrlPkg::DIV_WAIT_STEP) && !divDone;
	assign stopClass = (stepIf.iClass == cpuCtrlPkg::clsHalt) ||
		(stepIf.iClass == cpuCtrlPkg::clsIllegal);

	always_comb begin
		phaseD = phaseQ;
		stepD = stepQ;
		case (phaseQ)
			cpuCtrlPkg::phIdle: phaseD = cpuCtrlPkg::phFetch0;
			cpuCtrlPkg::phFetch0: phaseD = cpuCtrlPkg::phFetch1;
			cpuCtrlPkg::phFetch1: phaseD = cpuCtrlPkg::phFetch2;
			cpuCtrlPkg::phFetch2: begin
				phaseD = cpuCtrlPkg::phExecute;
				stepD = 3'd0;
			end
			cpuCtrlPkg::phExecute: begin
				if (stepQ == 3'd0 && stepIf.iClass == cpuCtrlPkg::clsRestart) begin
					phaseD = cpuCtrlPkg::phIdle;  // Back to fetch, no work done
				end else if (stepQ == 3'd0 && stopClass) begin
					phaseD = cpuCtrlPkg::phHalted;
				end else if (divWait) begin
					stepD = stepQ;  // Divider still busy
				end else if (stepQ == lastStep) begin
					phaseD = cpuCtrlPkg::phIdle;
					stepD = 3'd0;
				end else begin
					stepD = stepQ + 3'd1;
				end
			end
			cpuCtrlPkg::phHalted: phaseD = cpuCtrlPkg::phHalted;  // Only reset leaves
			default: phaseD = cpuCtrlPkg::phIdle;
		endcase
		if (stop) begin
			phaseD = cpuCtrlPkg::phHalted;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			phaseQ <= cpuCtrlPkg::phIdle;
			stepQ <= 3'd0;
		end else begin
			phaseQ <= phaseD;
			stepQ <= stepD;
		end
	end

	assign stepIf.phase = phaseQ;
	assign stepIf.step = stepQ;

endmodule

//--- src/controlWordGen.sv
module controlWordGen (
	ctrlStepIf.generator stepIf,
	output logic pcToBus,
	output logic mdrToBus,
	output logic zHighToBus,
	output logic zLowToBus,
	output logic baToBus,
	output logic immToBus,
	output logic regToBus,
	output logic pcLoad,
	output logic marLoad,
	output logic mdrLoad,
	output logic irLoad,
	output logic yLoad,
	output logic zLoad,
	output logic hiLoad,
	output logic loLoad,
	output logic regLoad,
	output logic r15Load,
	output logic conLoad,
	output logic memRead,
	output logic memWrite,
	output logic incPc,
	output logic divClear,
	output logic selA,
	output logic selB,
	output logic selC,
	output logic run,
	output cpuCtrlPkg::aluOpE aluOp
);

	logic isLoadImm;
	logic isAluReg;
	logic isStore;

	assign isLoadImm = (stepIf.iClass == cpuCtrlPkg::clsLoadImm);
	assign isAluReg = (stepIf.iClass == cpuCtrlPkg::clsAluReg);
	assign isStore = (stepIf.iClass == cpuCtrlPkg::clsStore);

	always_comb begin
		pcToBus = 1'b0;
		mdrToBus = 1'b0;
		zHighToBus = 1'b0;
		zLowToBus = 1'b0;
		baToBus = 1'b0;
		immToBus = 1'b0;
		regToBus = 1'b0;
		pcLoad = 1'b0;
		marLoad = 1'b0;
		mdrLoad = 1'b0;
		irLoad = 1'b0;
		yLoad = 1'b0;
		zLoad = 1'b0;
		hiLoad = 1'b0;
		loLoad = 1'b0;
		regLoad = 1'b0;
		r15Load = 1'b0;
		conLoad = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		incPc = 1'b0;
		divClear = 1'b0;
		selA = 1'b0;
		selB = 1'b0;
		selC = 1'b0;
		run = (stepIf.phase != cpuCtrlPkg::phHalted);
		case (stepIf.phase)
			cpuCtrlPkg::phFetch0: begin
				pcToBus = 1'b1;  // PC to MAR
				marLoad = 1'b1;
			end
			cpuCtrlPkg::phFetch1: begin
				memRead = 1'b1;
				mdrLoad = 1'b1;
				incPc = 1'b1;
			end
			cpuCtrlPkg::phFetch2: begin
				mdrToBus = 1'b1;  // Instruction into IR
				irLoad = 1'b1;
			end
			cpuCtrlPkg::phExecute: begin
				case (stepIf.iClass)
					cpuCtrlPkg::clsAluReg, cpuCtrlPkg::clsAluImm,
					cpuCtrlPkg::clsLoadImm: begin
						case (stepIf.step)
							3'd0: begin
								selB = 1'b1;
								baToBus = isLoadImm;  // ldi treats r0 as zero
								regToBus = !isLoadImm;
								yLoad = 1'b1;
							end
							3'd1: begin
								selC = isAluReg;
								regToBus = isAluReg;
								immToBus = !isAluReg;  // Sign-extended constant
								zLoad = 1'b1;
							end
							3'd2: begin
								zLowToBus = 1'b1;
								selA = 1'b1;
								regLoad = 1'b1;
							end
							default: ;
						endcase
					end
					cpuCtrlPkg::clsMul: begin
						case (stepIf.step)
							3'd0: begin
								selA = 1'b1;
								regToBus = 1'b1;
								yLoad = 1'b1;
							end
							3'd1: begin
								selB = 1'b1;
								regToBus = 1'b1;
								zLoad = 1'b1;
							end
							3'd2: begin
								zLowToBus = 1'b1;
								loLoad = 1'b1;
							end
							3'd3: begin
								zHighToBus = 1'b1;
								hiLoad = 1'b1;
							end
							default: ;
						endcase
					end
					cpuCtrlPkg::clsDiv: begin
						case (stepIf.step)
							3'd0: begin
								selA = 1'b1;
								regToBus = 1'b1;
								yLoad = 1'b1;
							end
							3'd1, 3'd2: begin
								selB = 1'b1;  // Divisor held while the divider runs
								regToBus = 1'b1;
								zLoad = (stepIf.step == 3'd2);
							end
							3'd3: begin
								divClear = 1'b1;
								zLowToBus = 1'b1;
								loLoad = 1'b1;
							end
							3'd4: begin
								zHighToBus = 1'b1;
								hiLoad = 1'b1;
							end
							default: ;
						endcase
					end
					cpuCtrlPkg::clsUnary: begin
						selB = (stepIf.step == 3'd0);
						regToBus = selB;
						zLoad = selB;
						selA = (stepIf.step == 3'd1);
						zLowToBus = selA;
						regLoad = selA;
					end
					cpuCtrlPkg::clsBranch: begin
						case (stepIf.step)
							3'd0: begin
								selA = 1'b1;
								regToBus = 1'b1;
								conLoad = 1'b1;  // Evaluate condition on Ra
							end
							3'd1: begin
								pcToBus = 1'b1;
								yLoad = 1'b1;
							end
							3'd2: begin
								immToBus = 1'b1;
								zLoad = 1'b1;
							end
							3'd3: begin
								zLowToBus = 1'b1;
								pcLoad = 1'b1;
							end
							default: ;
						endcase
					end
					cpuCtrlPkg::clsLoad, cpuCtrlPkg::clsStore: begin
						case (stepIf.step)
							3'd0: begin
								selB = 1'b1;
								baToBus = 1'b1;
								yLoad = 1'b1;
							end
							3'd1: begin
								immToBus = 1'b1;
								zLoad = 1'b1;  // Effective address
							end
							3'd2: begin
								zLowToBus = 1'b1;
								marLoad = 1'b1;
							end
							3'd3: begin
								memRead = !isStore;
								mdrLoad = 1'b1;
								selA = isStore;  // Store data from Ra
								baToBus = isStore;
							end
							3'd4: begin
								mdrToBus = 1'b1;
								memWrite = isStore;
								selA = !isStore;
								regLoad = !isStore;
							end
							default: ;
						endcase
					end
					cpuCtrlPkg::clsJumpReg: begin
						selA = 1'b1;
						regToBus = 1'b1;
						pcLoad = 1'b1;
					end
					cpuCtrlPkg::clsJumpLink: begin
						incPc = (stepIf.step == 3'd0);
						r15Load = (stepIf.step == 3'd1);  // Return address to r15
						pcToBus = r15Load;
						selA = (stepIf.step == 3'd2);
						regToBus = selA;
						pcLoad = selA;
					end
					default: ;  // Restart, halt and illegal do nothing here
				endcase
			end
			default: ;
		endcase
		aluOp = zLoad ? stepIf.aluOp : cpuCtrlPkg::aluNone;
	end

endmodule

//--- src/cpuControl.sv
module cpuControl (
	input logic clk,
	input logic rstN,
	input logic stop,
	input logic divDone,
	input cpuCtrlPkg::instrT ir,
	output logic pcToBus,
	output logic mdrToBus,
	output logic zHighToBus,
	output logic zLowToBus,
	output logic baToBus,
	output logic immToBus,
	output logic regToBus,
	output logic pcLoad,
	output logic marLoad,
	output logic mdrLoad,
	output logic irLoad,
	output logic yLoad,
	output logic zLoad,
	output logic hiLoad,
	output logic loLoad,
	output logic regLoad,
	output logic r15Load,
	output logic conLoad,
	output logic memRead,
	output logic memWrite,
	output logic incPc,
	output logic divClear,
	output logic selA,
	output logic selB,
	output logic selC,
	output logic run,
	output cpuCtrlPkg::aluOpE aluOp
);

	ctrlStepIf stepIf ();  // Class, operation, phase and step

	opcodeDecoder uDecoder (
		.ir(ir),
		.stepIf(stepIf)
	);

	stepSequencer uSequencer (
		.clk(clk),
		.rstN(rstN),
		.stop(stop),
		.divDone(divDone),
		.stepIf(stepIf)
	);

	// Strobe outputs match the generator's port names
	controlWordGen uGenerator (
		.stepIf(stepIf),
		.*
	);

endmodule

//--- include/instrTable.svh
`ifndef INSTR_TABLE_SVH
`define INSTR_TABLE_SVH

typedef struct packed {
	cpuCtrlPkg::opcodeT opcode;
	cpuCtrlPkg::stepT lastStep;   // Final execute step
	logic [1:0] regLoads;         // Expected strobe counts per instruction
	logic [1:0] pcLoads;
	logic [1:0] memWrites;
	logic [1:0] hiLoads;
	logic [1:0] loLoads;
	logic [1:0] r15Loads;
	cpuCtrlPkg::aluOpE aluOp;     // Expected while zLoad is high
} instrRowT;

localparam int NUM_ROWS = 24;

// Restart and halt come last, halt ends the sequence
localparam instrRowT INSTR_TABLE [NUM_ROWS] = '{
	'{cpuCtrlPkg::OPC_LD, 3'd4, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluAdd},
	'{cpuCtrlPkg::OPC_LDI, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluAdd},
	'{cpuCtrlPkg::OPC_ST, 3'd4, 2'd0, 2'd0, 2'd1, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluAdd},
	'{cpuCtrlPkg::OPC_ADD, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluAdd},
	'{cpuCtrlPkg::OPC_SUB, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluSub},
	'{cpuCtrlPkg::OPC_AND, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluAnd},
	'{cpuCtrlPkg::OPC_OR, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluOr},
	'{cpuCtrlPkg::OPC_SHR, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluShr},
	'{cpuCtrlPkg::OPC_SHRA, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluShra},
	'{cpuCtrlPkg::OPC_SHL, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluShl},
	'{cpuCtrlPkg::OPC_ROR, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluRor},
	'{cpuCtrlPkg::OPC_ROL, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluRol},
	'{cpuCtrlPkg::OPC_ADDI, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluAdd},
	'{cpuCtrlPkg::OPC_ANDI, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluAnd},
	'{cpuCtrlPkg::OPC_ORI, 3'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluOr},
	'{cpuCtrlPkg::OPC_MUL, 3'd3, 2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd0, cpuCtrlPkg::aluMul},
	'{cpuCtrlPkg::OPC_DIV, 3'd4, 2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd0, cpuCtrlPkg::aluDiv},
	'{cpuCtrlPkg::OPC_NEG, 3'd1, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluNeg},
	'{cpuCtrlPkg::OPC_NOT, 3'd1, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluNot},
	'{cpuCtrlPkg::OPC_BR, 3'd3, 2'd0, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluBranch},
	'{cpuCtrlPkg::OPC_JR, 3'd0, 2'd0, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluNone},
	'{cpuCtrlPkg::OPC_JAL, 3'd2, 2'd0, 2'd1, 2'd0, 2'd0, 2'd0, 2'd1, cpuCtrlPkg::aluNone},
	'{cpuCtrlPkg::OPC_RESTART, 3'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluNone},
	'{cpuCtrlPkg::OPC_HALT, 3'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, cpuCtrlPkg::aluNone}
};

`endif

//--- tests/tbCpuControl.sv
module tbCpuControl;
	timeunit 1ns;
	timeprecision 100ps;

	`include "instrTable.svh"

	logic clk;
	logic rstN;
	logic stop;
	logic divDone;
	cpuCtrlPkg::instrT ir;
	logic pcToBus, mdrToBus, zHighToBus, zLowToBus, baToBus, immToBus, regToBus;
	logic pcLoad, marLoad, mdrLoad, irLoad, yLoad, zLoad, hiLoad, loLoad;
	logic regLoad, r15Load, conLoad, memRead, memWrite, incPc, divClear;
	logic selA, selB, selC, run;
	cpuCtrlPkg::aluOpE aluOp;
	logic [24:0] strobes;  // Every strobe except run

	logic [31:0] lfsr = 32'h86a00b65;
	int cycleCount = 0;
	int cycleLimit = 0;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;

	cpuControl u_dut (.*);

	assign strobes = {pcToBus, mdrToBus, zHighToBus, zLowToBus, baToBus, immToBus, regToBus,
		pcLoad, marLoad, mdrLoad, irLoad, yLoad, zLoad, hiLoad, loLoad, regLoad, r15Load,
		conLoad, memRead, memWrite, incPc, divClear, selA, selB, selC};

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, the DUT never reached the expected state",
				cycleCount);
			$display("test failed");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] value;
		logic fb;
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic int computeLimit();
		int total;
		int i;
		total = 0;
		for (i = 0; i < NUM_ROWS; i++) begin
			total += int'(INSTR_TABLE[i].lastStep) + 5;
		end
		total += 7;            // Longest divide wait
		total += 3 * (8 + 4);  // Resets with fetch checks
		total += 2 * 24 + 2;   // Halt windows and stop pulse
		return 2 * total;
	endfunction

	task automatic tick();
		@(negedge clk);  // Outputs settled before inputs change
	endtask

	task automatic reportValue(input string sig, input int got, input int exp);
		$display("[FAIL] %s = 0x%0h, expected 0x%0h", sig, got, exp);
		testErrors++;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (testErrors == 0) begin
			$display("done  %s: ok", name);
		end else begin
			testsFailed++;
			$display("done  %s: %0d errors", name, testErrors);
		end
		testErrors = 0;
	endtask

	task automatic applyReset();
		int i;
		rstN = 1'b0;
		stop = 1'b0;
		divDone = 1'b0;
		ir = '0;
		for (i = 0; i < 8; i++) begin
			tick();
		end
		rstN = 1'b1;
	endtask

	// Idle, then fetch0 to fetch2
	task automatic checkFetchPattern(input string name);
		logic [24:0] expected [4];
		int i;
		expected[0] = 25'd0;
		expected[1] = (25'd1 << 24) | (25'd1 << 16);               // pcToBus, marLoad
		expected[2] = (25'd1 << 15) | (25'd1 << 6) | (25'd1 << 4); // mdrLoad, memRead, incPc
		expected[3] = (25'd1 << 23) | (25'd1 << 14);               // mdrToBus, irLoad
		for (i = 0; i < 4; i++) begin
			if (i > 0) begin
				tick();
			end
			if (!run) begin
				reportValue("run", int'(run), 1);
			end
			if (strobes != expected[i]) begin
				reportValue("strobes", int'(strobes), int'(expected[i]));
			end
		end
		finishTest(name);
	endtask

	task automatic checkStaysHalted();
		int i;
		for (i = 0; i < 24; i++) begin
			tick();
			if (irLoad) begin
				$display("[FAIL] irLoad pulsed while the CPU should stay halted");
				testErrors++;
			end
			if (i >= 1 && run) begin
				reportValue("run", int'(run), 0);
			end
			if (i >= 1 && strobes != 25'd0) begin
				reportValue("strobes", int'(strobes), 0);
			end
		end
	endtask

	// Starts and ends on the negedge where irLoad is seen
	task automatic runRow(input int index, input instrRowT row);
		logic [31:0] ra;
		logic [31:0] rb;
		logic [31:0] rc;
		cpuCtrlPkg::aluOpE expOp;
		int delay;
		int t;
		int regLoads, pcLoads, memWrites, hiLoads, loLoads, r15Loads, divClears;
		int zLoads;
		int expZLoads;
		ra = takeBits(4);
		rb = takeBits(4);
		rc = takeBits(4);
		delay = 0;
		if (row.opcode == cpuCtrlPkg::OPC_DIV) begin
			delay = int'(takeBits(3));
		end
		ir = {row.opcode, ra[3:0], rb[3:0], rc[3:0], 15'd0};
		if (row.opcode == cpuCtrlPkg::OPC_HALT) begin
			checkStaysHalted();
			finishTest($sformatf("row %0d opcode 0x%02h halt", index, row.opcode));
			return;
		end
		t = 0;
		regLoads = 0;
		pcLoads = 0;
		memWrites = 0;
		hiLoads = 0;
		loLoads = 0;
		r15Loads = 0;
		divClears = 0;
		zLoads = 0;
		do begin
			tick();
			t++;
			regLoads += int'(regLoad);
			pcLoads += int'(pcLoad);
			memWrites += int'(memWrite);
			hiLoads += int'(hiLoad);
			loLoads += int'(loLoad);
			r15Loads += int'(r15Load);
			divClears += int'(divClear);
			zLoads += int'(zLoad);
			expOp = zLoad ? row.aluOp : cpuCtrlPkg::aluNone;
			if (aluOp != expOp) begin
				reportValue("aluOp", int'(aluOp), int'(expOp));
			end
			// Divider finishes after the chosen number of wait edges
			divDone = (row.opcode == cpuCtrlPkg::OPC_DIV) && (t >= 2 + delay) && !irLoad;
		end while (!irLoad && t < 30);
		if (!irLoad) begin
			$display("[FAIL] no next instruction fetch within 30 cycles");
			testErrors++;
		end else if (t != int'(row.lastStep) + 5 + delay) begin
			reportValue("irLoad spacing", t, int'(row.lastStep) + 5 + delay);
		end
		if (regLoads != int'(row.regLoads)) begin
			reportValue("regLoad count", regLoads, int'(row.regLoads));
		end
		if (pcLoads != int'(row.pcLoads)) begin
			reportValue("pcLoad count", pcLoads, int'(row.pcLoads));
		end
		if (memWrites != int'(row.memWrites)) begin
			reportValue("memWrite count", memWrites, int'(row.memWrites));
		end
		if (hiLoads != int'(row.hiLoads)) begin
			reportValue("hiLoad count", hiLoads, int'(row.hiLoads));
		end
		if (loLoads != int'(row.loLoads)) begin
			reportValue("loLoad count", loLoads, int'(row.loLoads));
		end
		if (r15Loads != int'(row.r15Loads)) begin
			reportValue("r15Load count", r15Loads, int'(row.r15Loads));
		end
		if (divClears != ((row.opcode == cpuCtrlPkg::OPC_DIV) ? 1 : 0)) begin
			reportValue("divClear count", divClears,
				(row.opcode == cpuCtrlPkg::OPC_DIV) ? 1 : 0);
		end
		// Each instruction with an ALU operation loads Z exactly once
		expZLoads = (row.aluOp != cpuCtrlPkg::aluNone) ? 1 : 0;
		if (zLoads != expZLoads) begin
			reportValue("zLoad count", zLoads, expZLoads);
		end
		finishTest($sformatf("row %0d opcode 0x%02h", index, row.opcode));
	endtask

	initial begin
		int r;
		rstN = 1'b0;
		stop = 1'b0;
		divDone = 1'b0;
		ir = '0;
		cycleLimit = computeLimit();
		applyReset();
		checkFetchPattern("fetch after reset");
		for (r = 0; r < NUM_ROWS; r++) begin
			runRow(r, INSTR_TABLE[r]);
		end
		applyReset();
		checkFetchPattern("fetch after halt");
		ir = {cpuCtrlPkg::OPC_ADD, 27'd0};
		tick();  // Execute step 0
		stop = 1'b1;
		tick();
		stop = 1'b0;
		checkStaysHalted();
		finishTest("stop during execute");
		applyReset();
		checkFetchPattern("fetch after stop");
		$display("Summary: %0d tests, %0d failed", testsRun, testsFailed);
		if (testsFailed == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+include
src/cpuCtrlPkg.sv
src/ctrlStepIf.sv
src/opcodeDecoder.sv
src/stepSequencer.sv
src/controlWordGen.sv
src/cpuControl.sv
tests/tbCpuControl.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= sources.f
TOP        ?= tbCpuControl
LINT_TOP   ?= cpuControl
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --timing
PASS_TEXT  ?= test passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/instrTable.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
